// File: hdl/xintf_bridge_settings.svh
`ifndef XINTF_BRIDGE_SETTINGS_SVH
`define XINTF_BRIDGE_SETTINGS_SVH

// Width of the XINTF address bus and of every mailbox RAM address
`define XB_ADDR_W 9

// Width of the XINTF data bus and of every mailbox word
`define XB_DATA_W 16

// Top word of the address map
// A write here rings the doorbell and a read returns the status word
`define XB_DOORBELL_ADDR 511

// Cycles with CS and WE both low before a DSP write is trusted
// The XINTF strobes settle slower than the data lines on the board
`define XB_SETTLE_CNT 3

`endif

// File: hdl/xintf_bridge_pkg.sv
`include "xintf_bridge_settings.svh"

package xintf_bridge_pkg;

	// Transform applied to every word of a job
	typedef enum logic [1:0]
	{
		OP_COPY       = 2'd0,
		OP_INVERT     = 2'd1,
		OP_SWAP       = 2'd2,
		OP_PREFIX_SUM = 2'd3
	} xb_opcode_e;

	// Engine FSM states
	// DRAIN lets the last words leave the read and write stages before ack
	typedef enum logic [1:0]
	{
		ENG_IDLE  = 2'd0,
		ENG_RUN   = 2'd1,
		ENG_DRAIN = 2'd2,
		ENG_ACK   = 2'd3
	} xb_eng_state_e;

	// Command word written by the DSP to the doorbell address
	typedef struct packed
	{
		xb_opcode_e                            opcode;
		logic [`XB_DATA_W-3-`XB_ADDR_W:0]      rsvd;
		logic [`XB_ADDR_W-1:0]                 count;
	} xb_cmd_t;

	// Status word the DSP polls at the doorbell address
	typedef struct packed
	{
		logic       busy;
		logic [6:0] rsvd;
		logic [7:0] jobs;
	} xb_status_t;

endpackage

// File: hdl/dpbram_port_if.sv
`include "xintf_bridge_settings.svh"

// One port of a mailbox block RAM
interface dpbram_port_if;

	logic [`XB_ADDR_W-1:0] addr;
	logic                  ce;
	logic                  we;
	logic [`XB_DATA_W-1:0] din;
	// Read data, valid the cycle after ce was high
	logic [`XB_DATA_W-1:0] dout;

	// The block that owns the port and issues accesses
	modport master
	(
		output addr,
		output ce,
		output we,
		output din,
		input  dout
	);

	// The RAM itself
	modport slave
	(
		input  addr,
		input  ce,
		input  we,
		input  din,
		output dout
	);

endinterface

// File: hdl/dpbram.sv
`include "xintf_bridge_settings.svh"

// True dual-port block RAM used for both mailboxes
// Both ports are read-first and have one cycle of read latency
module dpbram
(
	input logic           i_clk,
	dpbram_port_if.slave  port_a,
	dpbram_port_if.slave  port_b
);

	localparam int ADDR_W = `XB_ADDR_W;
	localparam int DATA_W = `XB_DATA_W;
	localparam int DEPTH  = 2 ** ADDR_W;

	logic [DATA_W-1:0] mem [0:DEPTH-1];

	// Both ports live in one process so the array has a single driver
	// The design never lets the two ports write the same word at once
	always_ff @(posedge i_clk)
	begin
		if (port_a.ce)
		begin
			if (port_a.we)
			begin
				mem[port_a.addr] <= port_a.din;
			end
			// Old contents come back on a write
			port_a.dout <= mem[port_a.addr];
		end

		if (port_b.ce)
		begin
			if (port_b.we)
			begin
				mem[port_b.addr] <= port_b.din;
			end
			port_b.dout <= mem[port_b.addr];
		end
	end

endmodule

// File: hdl/xintf_bus_mux.sv
`include "xintf_bridge_settings.svh"

// DSP side of the bridge
// Decodes the XINTF strobes into mailbox RAM accesses and owns the doorbell
module xintf_bus_mux
(
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_nz_cs,
	input  logic                          i_nz_we,
	input  logic [`XB_ADDR_W-1:0]         i_z_xa,
	inout  wire logic [`XB_DATA_W-1:0]    io_z_xd,
	dpbram_port_if.master                 wr_port,
	dpbram_port_if.master                 rd_port,
	output logic                          o_req,
	output xintf_bridge_pkg::xb_cmd_t     o_cmd,
	input  logic                          i_ack
);

	import xintf_bridge_pkg::*;

	localparam int ADDR_W = `XB_ADDR_W;
	localparam int DATA_W = `XB_DATA_W;
	localparam int CNT_W  = $clog2(`XB_SETTLE_CNT + 1);
	localparam logic [CNT_W-1:0]  SETTLE  = CNT_W'(`XB_SETTLE_CNT);
	localparam logic [ADDR_W-1:0] DB_ADDR = ADDR_W'(`XB_DOORBELL_ADDR);

	logic             wr_act;
	logic             rd_act;
	logic             at_db;
	logic             settled;
	logic             db_fire;
	logic [CNT_W-1:0] cnt;
	logic             busy;
	logic             ack_q;
	logic             o_req_q;
	logic [7:0]       jobs;
	xb_status_t       status;

	// Both XINTF strobes are active low
	assign wr_act = ~i_nz_cs & ~i_nz_we;
	assign rd_act = ~i_nz_cs & i_nz_we;
	assign at_db  = (i_z_xa == DB_ADDR);

	assign settled = wr_act & (cnt == SETTLE);
	// Fires on the edge that takes the counter to the threshold, so once per strobe
	assign db_fire = wr_act & at_db & (cnt == SETTLE - 1'b1);

	// The write mailbox only sees a write after the strobe has settled
	// The doorbell word never lands in the RAM
	assign wr_port.addr = i_z_xa;
	assign wr_port.ce   = settled & ~at_db;
	assign wr_port.we   = settled & ~at_db;
	assign wr_port.din  = (settled & ~at_db) ? io_z_xd : '0;

	// Read mailbox address tracks the bus so data is ready one cycle after CS
	assign rd_port.addr = i_z_xa;
	assign rd_port.ce   = rd_act;
	assign rd_port.we   = 1'b0;
	assign rd_port.din  = '0;

	assign status.busy = busy;
	assign status.rsvd = '0;
	assign status.jobs = jobs;

	// The doorbell address reads back status instead of RAM contents
	assign io_z_xd = rd_act ? (at_db ? DATA_W'(status) : rd_port.dout) : 'z;

	assign o_req = o_req_q;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			cnt     <= '0;
			o_req_q <= 1'b0;
			busy    <= 1'b0;
			ack_q   <= 1'b0;
			jobs    <= '0;
		end
		else
		begin
			// Saturating settle counter that clears whenever the write strobe drops
			if (!wr_act)
				cnt <= '0;
			else if (cnt != SETTLE)
				cnt <= cnt + 1'b1;

			ack_q <= i_ack;

			// Busy already covers req and ack, so a new job only starts from idle
			if (db_fire && !busy)
			begin
				busy    <= 1'b1;
				o_req_q <= 1'b1;
			end
			else if (o_req_q && i_ack)
			begin
				o_req_q <= 1'b0;
			end

			// Job is complete once the engine has dropped ack
			if (ack_q && !i_ack)
			begin
				busy <= 1'b0;
				jobs <= jobs + 1'b1;
			end
		end
	end

	// Command holds while req is high since it only loads when idle
	always_ff @(posedge i_clk)
	begin
		if (db_fire && !busy)
			o_cmd <= xb_cmd_t'(io_z_xd);
	end

endmodule

// File: hdl/block_engine.sv
`include "xintf_bridge_settings.svh"

// FPGA side of the bridge
// Streams a block from the write mailbox, transforms it, stores it in the read mailbox
module block_engine
(
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_req,
	input  xintf_bridge_pkg::xb_cmd_t     i_cmd,
	output logic                          o_ack,
	dpbram_port_if.master                 src,
	dpbram_port_if.master                 dst
);

	import xintf_bridge_pkg::*;

	localparam int ADDR_W = `XB_ADDR_W;
	localparam int DATA_W = `XB_DATA_W;
	localparam int HALF_W = DATA_W / 2;

	xb_eng_state_e      state;
	xb_opcode_e         op_q;
	logic [ADDR_W-1:0]  cnt_q;
	logic [ADDR_W-1:0]  rd_addr;
	logic [ADDR_W-1:0]  rd_addr_q;
	logic [ADDR_W-1:0]  wr_addr_q;
	logic               rd_vld;
	logic               wr_vld;
	logic [DATA_W-1:0]  sum;
	logic [DATA_W-1:0]  result;
	logic [DATA_W-1:0]  wr_data_q;

	// Read stage, one source read per cycle while running
	assign src.addr = rd_addr;
	assign src.ce   = (state == ENG_RUN);
	assign src.we   = 1'b0;
	assign src.din  = '0;

	// Write stage, registered one cycle behind the returned data
	assign dst.addr = wr_addr_q;
	assign dst.ce   = wr_vld;
	assign dst.we   = wr_vld;
	assign dst.din  = wr_data_q;

	assign o_ack = (state == ENG_ACK);

	// Transform of the word returned by the write mailbox
	always_comb
	begin
		case (op_q)
			OP_COPY:       result = src.dout;
			OP_INVERT:     result = ~src.dout;
			OP_SWAP:       result = {src.dout[HALF_W-1:0], src.dout[DATA_W-1:HALF_W]};
			OP_PREFIX_SUM: result = sum + src.dout;
			default:       result = src.dout;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			state   <= ENG_IDLE;
			rd_addr <= '0;
			rd_vld  <= 1'b0;
			wr_vld  <= 1'b0;
			sum     <= '0;
		end
		else
		begin
			// Two words in flight, one in the read stage and one in the write stage
			rd_vld <= (state == ENG_RUN);
			wr_vld <= rd_vld;

			// Running sum wraps at the data width
			if (rd_vld)
				sum <= sum + src.dout;

			case (state)
				ENG_IDLE:
				begin
					if (i_req)
					begin
						rd_addr <= '0;
						sum     <= '0;
						// A zero count is out of range, it just acks with no transfers
						state   <= (i_cmd.count == '0) ? ENG_DRAIN : ENG_RUN;
					end
				end
				ENG_RUN:
				begin
					rd_addr <= rd_addr + 1'b1;
					if (rd_addr == cnt_q - 1'b1)
						state <= ENG_DRAIN;
				end
				ENG_DRAIN:
				begin
					// Last result is being written this cycle when the read stage is empty
					if (!rd_vld)
						state <= ENG_ACK;
				end
				ENG_ACK:
				begin
					// Hold ack until the mux drops req
					if (!i_req)
						state <= ENG_IDLE;
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// Job parameters and pipeline payload
	always_ff @(posedge i_clk)
	begin
		if (state == ENG_IDLE && i_req)
		begin
			op_q  <= i_cmd.opcode;
			cnt_q <= i_cmd.count;
		end
		rd_addr_q <= rd_addr;
		wr_addr_q <= rd_addr_q;
		wr_data_q <= result;
	end

endmodule

// File: hdl/xintf_bridge.sv
`include "xintf_bridge_settings.svh"

// Mailbox bridge between the DSP XINTF bus and the FPGA block engine
// Data path is bus mux, write mailbox, engine, read mailbox and back to the bus mux
module xintf_bridge
(
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_nz_cs,
	input  logic                          i_nz_we,
	input  logic [`XB_ADDR_W-1:0]         i_z_xa,
	inout  wire logic [`XB_DATA_W-1:0]    io_z_xd
);

	import xintf_bridge_pkg::*;

	// DSP writes through wr_a, engine reads through wr_b
	dpbram_port_if wr_a ();
	dpbram_port_if wr_b ();
	// Engine writes through rd_b, DSP reads through rd_a
	dpbram_port_if rd_a ();
	dpbram_port_if rd_b ();

	logic    req;
	logic    ack;
	xb_cmd_t cmd;

	xintf_bus_mux u_bus_mux
	(
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_nz_cs (i_nz_cs),
		.i_nz_we (i_nz_we),
		.i_z_xa  (i_z_xa),
		.io_z_xd (io_z_xd),
		.wr_port (wr_a.master),
		.rd_port (rd_a.master),
		.o_req   (req),
		.o_cmd   (cmd),
		.i_ack   (ack)
	);

	dpbram u_wr_mbox
	(
		.i_clk  (i_clk),
		.port_a (wr_a.slave),
		.port_b (wr_b.slave)
	);

	block_engine u_engine
	(
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_req (req),
		.i_cmd (cmd),
		.o_ack (ack),
		.src   (wr_b.master),
		.dst   (rd_b.master)
	);

	dpbram u_rd_mbox
	(
		.i_clk  (i_clk),
		.port_a (rd_a.slave),
		.port_b (rd_b.slave)
	);

endmodule

// File: test/xintf_bridge_chk.sv
`include "xintf_bridge_settings.svh"

// Protocol checker bound into the bus mux and the block engine
// Watches the req/ack handshake and the DSP strobe rules
module xintf_bridge_chk
(
	input logic i_clk,
	input logic i_rst,
	input logic i_req,
	input logic i_ack,
	input logic i_nz_cs,
	input logic i_nz_we,
	input logic i_wr_ce,
	input logic i_xd_oe
);

	// Number of assertion failures seen so far
	int fail_cnt = 0;

	// DSP write cycle on the bus
	logic wr_strobe;

	assign wr_strobe = !i_nz_cs && !i_nz_we;

	// Once raised, req stays up until the engine answers with ack
	req_until_ack: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_req && !i_ack) |=> i_req)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("req fell before ack was seen");
	end

	// The engine only answers a pending request
	ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst)
		$rose(i_ack) |-> i_req)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("ack rose while req was low");
	end

	// A mailbox write can only come from a DSP write cycle
	// When ce first rises the strobe has already been low for the whole settle window
	wr_ce_needs_we: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_wr_ce |-> (wr_strobe && ($past(i_wr_ce) || $past(wr_strobe, `XB_SETTLE_CNT))))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("write mailbox ce high without a settled write strobe");
	end

	// The FPGA drives the data bus during DSP read cycles only
	drive_on_read: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_xd_oe |-> (!i_nz_cs && i_nz_we))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("data bus driven outside a read cycle");
	end

endmodule

bind xintf_bus_mux xintf_bridge_chk u_mux_chk
(
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_req   (o_req),
	.i_ack   (i_ack),
	.i_nz_cs (i_nz_cs),
	.i_nz_we (i_nz_we),
	.i_wr_ce (wr_port.ce),
	.i_xd_oe (rd_act)
);

// The engine never sees the DSP bus, so its strobe inputs sit idle
bind block_engine xintf_bridge_chk u_eng_chk
(
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_req   (i_req),
	.i_ack   (o_ack),
	.i_nz_cs (1'b1),
	.i_nz_we (1'b1),
	.i_wr_ce (1'b0),
	.i_xd_oe (1'b0)
);

// File: test/xintf_bridge_tb.sv
`include "xintf_bridge_settings.svh"

// Testbench for the XINTF mailbox bridge
// Plays the DSP on the bus and checks every job against a reference model
module xintf_bridge_tb;

	import xintf_bridge_pkg::*;

	localparam int ADDR_W     = `XB_ADDR_W;
	localparam int DATA_W     = `XB_DATA_W;
	localparam int CLK_PERIOD = 20;
	localparam int DRV_DLY    = 2;
	localparam int RST_CYCLES = 16;
	localparam int HOLD       = 6;
	localparam int GAP        = 2;
	localparam int N_JOB      = 32;
	localparam logic [ADDR_W-1:0] DB_ADDR = ADDR_W'(`XB_DOORBELL_ADDR);
	// Words written plus words read back, over all jobs
	localparam int WORDS_MOVED = 2 * (4 * N_JOB + 64 + 1 + 511) + N_JOB;
	// Doubled to leave room for status polls, plus a fixed margin
	localparam int WATCHDOG = ((2 * WORDS_MOVED + 400) * (HOLD + GAP) + RST_CYCLES) * CLK_PERIOD;

	// One word read back from the read mailbox, with what produced it
	typedef struct
	{
		xb_opcode_e        op;
		logic              first;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] din;
		logic [DATA_W-1:0] dout;
	} rd_entry_t;

	logic              clk;
	logic              rst;
	logic              nz_cs;
	logic              nz_we;
	logic [ADDR_W-1:0] z_xa;
	logic [DATA_W-1:0] xd_drv;
	logic              xd_en;
	wire  [DATA_W-1:0] z_xd;

	integer            seed;
	int                rnd;
	logic [7:0]        exp_jobs;
	logic [DATA_W-1:0] mbox [0:`XB_DOORBELL_ADDR-1];
	logic [DATA_W-1:0] rdata;
	xb_status_t        status;
	rd_entry_t         rd_q [$];
	rd_entry_t         ent;
	logic [DATA_W-1:0] ref_sum;
	logic [DATA_W-1:0] exp_word;

	// DSP side of the shared data bus, only driven during writes
	assign z_xd = xd_en ? xd_drv : 'z;

	xintf_bridge dut
	(
		.i_clk   (clk),
		.i_rst   (rst),
		.i_nz_cs (nz_cs),
		.i_nz_we (nz_we),
		.i_z_xa  (z_xa),
		.io_z_xd (z_xd)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Expected mailbox result for one word, sum holds the words before it
	function automatic logic [DATA_W-1:0] expected_word(input xb_opcode_e op,
		input logic [DATA_W-1:0] din, input logic [DATA_W-1:0] sum);
		case (op)
			OP_COPY:   return din;
			OP_INVERT: return ~din;
			OP_SWAP:   return {din[7:0], din[15:8]};
			default:   return sum + din;
		endcase
	endfunction

	function automatic xb_status_t expected_status(input logic busy, input logic [7:0] jobs);
		xb_status_t st;
		st      = '0;
		st.busy = busy;
		st.jobs = jobs;
		return st;
	endfunction

	function automatic xb_cmd_t make_cmd(input xb_opcode_e op, input int count);
		xb_cmd_t cmd;
		cmd        = '0;
		cmd.opcode = op;
		cmd.count  = ADDR_W'(count);
		return cmd;
	endfunction

	function automatic int assert_fails();
		return dut.u_bus_mux.u_mux_chk.fail_cnt + dut.u_engine.u_eng_chk.fail_cnt;
	endfunction

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_status(input string name, input xb_status_t got, input xb_status_t exp);
		if (got !== exp)
		begin
			$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// All bus activity starts a short delay after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#(DRV_DLY);
	endtask

	task automatic dsp_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input int hold);
		nz_cs  = 1'b0;
		nz_we  = 1'b0;
		z_xa   = addr;
		xd_drv = data;
		xd_en  = 1'b1;
		repeat (hold) next_cycle();
		nz_cs = 1'b1;
		nz_we = 1'b1;
		xd_en = 1'b0;
		repeat (GAP) next_cycle();
	endtask

	// Samples on the falling edge of the last strobe cycle, well after the data settles
	task automatic dsp_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		nz_cs = 1'b0;
		nz_we = 1'b1;
		z_xa  = addr;
		repeat (HOLD - 1) next_cycle();
		@(negedge clk);
		data = z_xd;
		next_cycle();
		nz_cs = 1'b1;
		repeat (GAP) next_cycle();
	endtask

	task automatic wait_idle(output xb_status_t st);
		logic [DATA_W-1:0] word;
		do
		begin
			dsp_read(DB_ADDR, word);
			st = xb_status_t'(word);
		end
		while (st.busy);
	endtask

	task automatic load_block(input int count);
		for (int i = 0; i < count; i++)
		begin
			rnd     = $random(seed);
			mbox[i] = rnd[DATA_W-1:0];
			dsp_write(ADDR_W'(i), mbox[i], HOLD);
		end
	endtask

	task automatic run_job(input xb_opcode_e op, input int count);
		xb_status_t st;
		dsp_write(DB_ADDR, make_cmd(op, count), HOLD);
		wait_idle(st);
		exp_jobs = exp_jobs + 1'b1;
		check_status("status", st, expected_status(1'b0, exp_jobs));
	endtask

	// Hands each word to the compare process along with its source word
	task automatic read_back(input xb_opcode_e op, input int count);
		logic [DATA_W-1:0] word;
		rd_entry_t         entry;
		for (int i = 0; i < count; i++)
		begin
			dsp_read(ADDR_W'(i), word);
			entry.op    = op;
			entry.first = (i == 0);
			entry.addr  = ADDR_W'(i);
			entry.din   = mbox[i];
			entry.dout  = word;
			rd_q.push_back(entry);
		end
	endtask

	// Compare process, the running sum restarts with each job
	always @(negedge clk)
	begin
		while (rd_q.size() > 0)
		begin
			ent = rd_q.pop_front();
			if (ent.first)
				ref_sum = '0;
			exp_word = expected_word(ent.op, ent.din, ref_sum);
			ref_sum  = ref_sum + ent.din;
			check_word($sformatf("io_z_xd at 0x%h", ent.addr), ent.dout, exp_word);
		end
	end

	always @(posedge clk)
	begin
		if (assert_fails() != 0)
		begin
			$display("A bound assertion on the handshake or the strobes failed");
			abort_run();
		end
	end

	initial
	begin
		#(WATCHDOG);
		$display("Timeout: the jobs did not finish within %0d time units", WATCHDOG);
		abort_run();
	end

	initial
	begin
		clk      = 1'b0;
		rst      = 1'b0;
		nz_cs    = 1'b1;
		nz_we    = 1'b1;
		z_xa     = '0;
		xd_drv   = '0;
		xd_en    = 1'b0;
		seed     = 19008;
		exp_jobs = '0;
		ref_sum  = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#(DRV_DLY);
		rst = 1'b1;
		next_cycle();

		// Idle status straight out of reset
		dsp_read(DB_ADDR, rdata);
		check_status("status", xb_status_t'(rdata), expected_status(1'b0, exp_jobs));

		// One job per opcode on fresh data
		for (int k = 0; k < 4; k++)
		begin
			load_block(N_JOB);
			run_job(xb_opcode_e'(k), N_JOB);
			read_back(xb_opcode_e'(k), N_JOB);
		end

		// Second doorbell lands while the first job is still running
		load_block(64);
		dsp_write(DB_ADDR, make_cmd(OP_INVERT, 64), HOLD);
		dsp_write(DB_ADDR, make_cmd(OP_COPY, 5), HOLD);
		dsp_read(DB_ADDR, rdata);
		check_status("status", xb_status_t'(rdata), expected_status(1'b1, exp_jobs));
		wait_idle(status);
		exp_jobs = exp_jobs + 1'b1;
		check_status("status", status, expected_status(1'b0, exp_jobs));
		read_back(OP_INVERT, 64);

		// Too short for the settle counter, so word 5 keeps its old value
		dsp_write(ADDR_W'(5), ~mbox[5], 2);
		run_job(OP_COPY, N_JOB);
		read_back(OP_COPY, N_JOB);

		// Smallest and largest block sizes
		load_block(1);
		run_job(OP_SWAP, 1);
		read_back(OP_SWAP, 1);
		load_block(511);
		run_job(OP_PREFIX_SUM, 511);
		read_back(OP_PREFIX_SUM, 511);

		wait (rd_q.size() == 0);
		repeat (2) next_cycle();
		if (assert_fails() == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
		begin
			abort_run();
		end
	end

endmodule

// File: xintf_bridge.f
+incdir+hdl
hdl/xintf_bridge_pkg.sv
hdl/dpbram_port_if.sv
hdl/dpbram.sv
hdl/xintf_bus_mux.sv
hdl/block_engine.sv
hdl/xintf_bridge.sv
test/xintf_bridge_chk.sv
test/xintf_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := xintf_bridge_tb
FILE_LIST := xintf_bridge.f
VFLAGS    := --timing --assert
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
